//--- common/ma_defs.svh
`ifndef MA_DEFS_SVH
`define MA_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////
`define WIDTH               32                  // data and address width
`define DMEM_AW             6                   // word index into data memory
`define DMEM_DEPTH          (1 << `DMEM_AW)     // 64 words

//////////////////////////////////////////////////////////////////////
// vectored interrupt controller config bank
//////////////////////////////////////////////////////////////////////
`define CONFREG_WIDTH       4                   // bits kept per vic register
`define CONFREGADDR_WIDTH   5                   // vic register index
`define CONFREG_COUNT       (1 << `CONFREGADDR_WIDTH)

// address bits 31..28 equal to this pick the vic bank
`define VIC_REGION          4'hF

`endif

//--- common/ma_pkg.sv
`include "ma_defs.svh"

package ma_pkg;

    // memory access request coming down from ex/mem
    typedef enum logic [1:0] {
        MA_NONE  = 2'b00,   // alu only
        MA_LOAD  = 2'b01,
        MA_STORE = 2'b10
    } ma_op_t;

    // write back control, rides along to the wb stage
    typedef struct packed {
        logic reg_write;    // regfile gets written
        logic mem_to_reg;   // load data instead of alu result
        logic valid;        // slot holds an instruction
    } wb_ctrl_t;

    //////////////////////////////////////////////////////////////////////
    // ma/wb pipeline register payload
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [4:0]        rdst;       // destination register
        logic [`WIDTH-1:0] pc;
        logic [`WIDTH-1:0] mem_data;   // load result, dmem or vic
        logic [`WIDTH-1:0] alu_rslt;
        wb_ctrl_t          wb;
    } mawb_t;

endpackage

//--- common/ma_req_if.sv
`include "ma_defs.svh"

// one access per cycle from the access control into a storage block
interface ma_req_if;

    logic                strobe;    // access presented this cycle
    logic                we;        // write on strobe
    logic [`DMEM_AW-1:0] index;     // word index, vic uses low bits only
    logic [`WIDTH-1:0]   wdata;     // store data

    // access control side
    modport master (
        output strobe,
        output we,
        output index,
        output wdata
    );

    // storage side
    modport slave (
        input strobe,
        input we,
        input index,
        input wdata
    );

endinterface

//--- design/ma_access_ctrl.sv
`include "ma_defs.svh"

module ma_access_ctrl (
    input  logic              clk,
    input  logic              i_rst,
    input  ma_pkg::ma_op_t    i_ma_op,        // none / load / store
    input  logic [`WIDTH-1:0] i_ma_alu_rslt,  // effective address
    input  logic [`WIDTH-1:0] i_ma_rs2_val,   // store data from regfile
    input  logic [`WIDTH-1:0] i_ma_mux_wb,    // store data forwarded from wb
    input  logic              i_op1_mem_s,    // forwarding select
    input  logic              i_ma_stall,
    ma_req_if.master          dmem_req,
    ma_req_if.master          vic_req,
    output logic              o_sel_vic       // load data comes from vic bank
);

    import ma_pkg::*;

    logic              is_vic;      // address falls in vic region
    logic              access;      // load or store while not stalled
    logic              is_store;
    logic [`WIDTH-1:0] st_data;     // store data after forwarding

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////
    assign is_vic   = (i_ma_alu_rslt[`WIDTH-1:`WIDTH-4] == `VIC_REGION);
    assign is_store = (i_ma_op == MA_STORE);
    // no strobe while stalled so a store lands only once
    assign access   = ((i_ma_op == MA_LOAD) || is_store) && !i_ma_stall;

    assign st_data  = i_op1_mem_s ? i_ma_mux_wb : i_ma_rs2_val;

    //////////////////////////////////////////////////////////////////////
    // request outputs
    //////////////////////////////////////////////////////////////////////
    assign dmem_req.strobe = access && !is_vic;
    assign dmem_req.we     = is_store;
    assign dmem_req.index  = i_ma_alu_rslt[`DMEM_AW+1:2];  // upper bits dropped so it wraps
    assign dmem_req.wdata  = st_data;

    assign vic_req.strobe  = access && is_vic;
    assign vic_req.we      = is_store;
    assign vic_req.index   = {{(`DMEM_AW-`CONFREGADDR_WIDTH){1'b0}},
                              i_ma_alu_rslt[`CONFREGADDR_WIDTH+1:2]};
    assign vic_req.wdata   = st_data;  // bank keeps low bits

    assign o_sel_vic = is_vic;

    // op code 2'b11 is unused and an x on op or stall leaves the strobes unknown
    a_op_legal : assert property (@(posedge clk) disable iff (i_rst)
        !$isunknown({i_ma_op, i_ma_stall}) &&
        (i_ma_op inside {MA_NONE, MA_LOAD, MA_STORE}));

endmodule

//--- design/ma_dmem.sv
`include "ma_defs.svh"

module ma_dmem (
    input  logic              clk,
    ma_req_if.slave           req,
    output logic [`WIDTH-1:0] o_rdata    // combinational read at index
);

    // local word array, no reset on contents
    logic [`WIDTH-1:0] mem [`DMEM_DEPTH];

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (req.strobe && req.we) begin
            mem[req.index] <= req.wdata;   // lands at end of access cycle
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////
    // same cycle as the strobe, no miss path
    assign o_rdata = mem[req.index];

    // x on store data means the forwarding path is broken upstream
    a_wdata_known : assert property (@(posedge clk)
        (req.strobe && req.we) |-> !$isunknown(req.wdata));

endmodule

//--- design/ma_vic_regs.sv
`include "ma_defs.svh"

module ma_vic_regs (
    input  logic              clk,
    input  logic              i_rst,
    ma_req_if.slave           req,
    output logic [`WIDTH-1:0] o_rdata    // zero extended register value
);

    logic [`CONFREG_WIDTH-1:0]     regs [`CONFREG_COUNT];
    logic [`CONFREGADDR_WIDTH-1:0] idx;   // low bits of shared index

    assign idx = req.index[`CONFREGADDR_WIDTH-1:0];

    //////////////////////////////////////////////////////////////////////
    // config registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < `CONFREG_COUNT; i++) begin
                regs[i] <= '0;   // priorities and enables start cleared
            end
        end else if (req.strobe && req.we) begin
            regs[idx] <= req.wdata[`CONFREG_WIDTH-1:0];  // narrow port
        end
    end

    // read back, upper bits zero
    assign o_rdata = {{(`WIDTH-`CONFREG_WIDTH){1'b0}}, regs[idx]};

    // access control must never hand over an index past the bank
    a_idx_range : assert property (@(posedge clk) disable iff (i_rst)
        req.strobe |-> (req.index < `CONFREG_COUNT));

endmodule

//--- design/ma_wb_reg.sv
`include "ma_defs.svh"

module ma_wb_reg (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_flush,        // hazard unit kills the slot
    input  logic              i_stall,        // hazard unit holds the slot
    input  logic              i_sel_vic,      // access went to vic bank
    input  logic [`WIDTH-1:0] i_dmem_rdata,
    input  logic [`WIDTH-1:0] i_vic_rdata,
    input  logic [4:0]        i_rdst,
    input  logic [`WIDTH-1:0] i_pc,
    input  logic [`WIDTH-1:0] i_alu_rslt,
    input  ma_pkg::wb_ctrl_t  i_wb,
    output ma_pkg::mawb_t     o_mawb
);

    import ma_pkg::*;

    logic [`WIDTH-1:0] mem_data;   // combined load result
    mawb_t             nxt;

    //////////////////////////////////////////////////////////////////////
    // load source and payload
    //////////////////////////////////////////////////////////////////////
    assign mem_data = i_sel_vic ? i_vic_rdata : i_dmem_rdata;

    always_comb begin
        nxt.rdst     = i_rdst;
        nxt.pc       = i_pc;
        nxt.mem_data = mem_data;
        nxt.alu_rslt = i_alu_rslt;
        nxt.wb       = i_wb;
    end

    //////////////////////////////////////////////////////////////////////
    // ma/wb register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_mawb <= '0;
        end else if (i_flush) begin
            o_mawb <= '0;       // bubble with valid and reg_write low
        end else if (!i_stall) begin
            o_mawb <= nxt;
        end                     // stall keeps previous slot
    end

    // an x on flush or stall would silently keep or drop the slot
    a_hazard_known : assert property (@(posedge clk) disable iff (i_rst)
        !$isunknown({i_flush, i_stall}));

endmodule

//--- design/stage_ma.sv
`include "ma_defs.svh"

module stage_ma (
    input  logic              clk,
    input  logic              i_rst,
    input  ma_pkg::wb_ctrl_t  i_ma_wb,         // write back control
    input  ma_pkg::ma_op_t    i_ma_op,         // memory access control
    input  logic [`WIDTH-1:0] i_ma_alu_rslt,   // alu result, also address
    input  logic [`WIDTH-1:0] i_ma_rs2_val,    // source reg 2 value
    input  logic [`WIDTH-1:0] i_ma_pc,
    input  logic [4:0]        i_ma_rdst,       // destination reg
    input  logic [`WIDTH-1:0] i_ma_mux_wb,     // forwarded wb result
    input  logic              i_op1_mem_s,     // forwarding unit select
    input  logic              i_ma_flush,
    input  logic              i_ma_stall,

    output logic [4:0]        o_ma_rdst,
    output logic [`WIDTH-1:0] o_ma_pc,
    output logic [`WIDTH-1:0] o_ma_mem_out,    // load result
    output logic [`WIDTH-1:0] o_ma_alu_rslt,
    output ma_pkg::wb_ctrl_t  o_ma_wb
);

    import ma_pkg::*;

    logic [`WIDTH-1:0] dmem_rdata;
    logic [`WIDTH-1:0] vic_rdata;
    logic              sel_vic;    // current access targets vic
    mawb_t             mawb;

    ma_req_if dmem_req ();
    ma_req_if vic_req ();

    //////////////////////////////////////////////////////////////////////
    // access routing
    //////////////////////////////////////////////////////////////////////
    ma_access_ctrl access_ctrl_i (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_ma_op       (i_ma_op),
        .i_ma_alu_rslt (i_ma_alu_rslt),
        .i_ma_rs2_val  (i_ma_rs2_val),
        .i_ma_mux_wb   (i_ma_mux_wb),
        .i_op1_mem_s   (i_op1_mem_s),
        .i_ma_stall    (i_ma_stall),
        .dmem_req      (dmem_req.master),
        .vic_req       (vic_req.master),
        .o_sel_vic     (sel_vic)
    );

    // storage side by side
    ma_dmem dmem_i (
        .clk     (clk),
        .req     (dmem_req.slave),
        .o_rdata (dmem_rdata)
    );

    ma_vic_regs vic_regs_i (
        .clk     (clk),
        .i_rst   (i_rst),
        .req     (vic_req.slave),
        .o_rdata (vic_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // ma/wb register
    //////////////////////////////////////////////////////////////////////
    ma_wb_reg wb_reg_i (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_flush      (i_ma_flush),
        .i_stall      (i_ma_stall),
        .i_sel_vic    (sel_vic),
        .i_dmem_rdata (dmem_rdata),
        .i_vic_rdata  (vic_rdata),
        .i_rdst       (i_ma_rdst),
        .i_pc         (i_ma_pc),
        .i_alu_rslt   (i_ma_alu_rslt),
        .i_wb         (i_ma_wb),
        .o_mawb       (mawb)
    );

    // unpack payload onto stage outputs
    assign o_ma_rdst     = mawb.rdst;
    assign o_ma_pc       = mawb.pc;
    assign o_ma_mem_out  = mawb.mem_data;
    assign o_ma_alu_rslt = mawb.alu_rslt;
    assign o_ma_wb       = mawb.wb;

endmodule

//--- test/ma_checker.sv
`include "ma_defs.svh"

module ma_checker (
    input  logic              clk,
    input  logic              i_rst,
    input  logic              i_exp_valid,     // expected payload presented this cycle
    input  ma_pkg::mawb_t     i_exp,
    input  logic              i_exp_mem_chk,   // mem_data defined in the model
    input  logic [4:0]        i_rdst,
    input  logic [`WIDTH-1:0] i_pc,
    input  logic [`WIDTH-1:0] i_mem_out,
    input  logic [`WIDTH-1:0] i_alu_rslt,
    input  ma_pkg::wb_ctrl_t  i_wb,
    output int                o_checked,
    output int                o_errors
);

    import ma_pkg::*;

    mawb_t exp_q [$];
    bit    chk_q [$];
    logic  rst_q;      // reset seen at last rising edge

    initial begin
        o_checked = 0;
        o_errors  = 0;
    end

    task automatic compare_field(input string name, input logic [`WIDTH-1:0] got,
                                 input logic [`WIDTH-1:0] exp);
        if (got !== exp) begin
            o_errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // capture at the rising edge, compare at the falling edge
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        rst_q <= i_rst;
        if (i_exp_valid) begin
            exp_q.push_back(i_exp);     // result due after this edge
            chk_q.push_back(i_exp_mem_chk);
        end
    end

    always @(negedge clk) begin
        mawb_t e;
        bit    mem_ok;
        bit    check;
        e      = '0;                    // zero payload while in reset
        mem_ok = 1'b1;
        check  = (rst_q === 1'b1);
        if (rst_q === 1'b0 && exp_q.size() > 0) begin
            e      = exp_q.pop_front();
            mem_ok = chk_q.pop_front();
            check  = 1'b1;
            o_checked++;
        end
        if (check) begin
            compare_field("rdst", i_rdst, e.rdst);
            compare_field("pc", i_pc, e.pc);
            if (mem_ok) compare_field("mem_out", i_mem_out, e.mem_data);
            compare_field("alu_rslt", i_alu_rslt, e.alu_rslt);
            compare_field("wb", i_wb, e.wb);
        end
    end

endmodule

//--- test/tb_stage_ma.sv
`include "ma_defs.svh"

module tb_stage_ma;

    import ma_pkg::*;

    localparam int NUM_OPS    = 400;
    localparam int MAX_CYCLES = NUM_OPS + 100;   // reset and drain fit in the margin

    logic              clk = 1'b0;
    logic              i_rst;
    wb_ctrl_t          i_ma_wb;
    ma_op_t            i_ma_op;
    logic [`WIDTH-1:0] i_ma_alu_rslt;
    logic [`WIDTH-1:0] i_ma_rs2_val;
    logic [`WIDTH-1:0] i_ma_pc;
    logic [4:0]        i_ma_rdst;
    logic [`WIDTH-1:0] i_ma_mux_wb;
    logic              i_op1_mem_s;
    logic              i_ma_flush;
    logic              i_ma_stall;
    logic [4:0]        o_ma_rdst;
    logic [`WIDTH-1:0] o_ma_pc;
    logic [`WIDTH-1:0] o_ma_mem_out;
    logic [`WIDTH-1:0] o_ma_alu_rslt;
    wb_ctrl_t          o_ma_wb;

    mawb_t             exp_pay;        // payload due after the coming edge
    logic              exp_valid;
    logic              exp_mem_chk;    // model knows mem_data
    int                checked;
    int                errors;
    int                cycles = 0;
    logic [15:0]       lfsr = 16'd92;

    // reference state
    logic [`WIDTH-1:0] mem_model [`DMEM_DEPTH];
    bit                written [`DMEM_DEPTH];
    logic [3:0]        vic_model [`CONFREG_COUNT];
    mawb_t             prev_exp = '0;
    bit                prev_chk = 1'b1;

    always #20 clk = ~clk;

    stage_ma dut_i (
        .clk (clk), .i_rst (i_rst), .i_ma_wb (i_ma_wb), .i_ma_op (i_ma_op),
        .i_ma_alu_rslt (i_ma_alu_rslt), .i_ma_rs2_val (i_ma_rs2_val), .i_ma_pc (i_ma_pc),
        .i_ma_rdst (i_ma_rdst), .i_ma_mux_wb (i_ma_mux_wb), .i_op1_mem_s (i_op1_mem_s),
        .i_ma_flush (i_ma_flush), .i_ma_stall (i_ma_stall), .o_ma_rdst (o_ma_rdst),
        .o_ma_pc (o_ma_pc), .o_ma_mem_out (o_ma_mem_out), .o_ma_alu_rslt (o_ma_alu_rslt),
        .o_ma_wb (o_ma_wb)
    );

    ma_checker chk_i (
        .clk (clk), .i_rst (i_rst), .i_exp_valid (exp_valid), .i_exp (exp_pay),
        .i_exp_mem_chk (exp_mem_chk), .i_rdst (o_ma_rdst), .i_pc (o_ma_pc),
        .i_mem_out (o_ma_mem_out), .i_alu_rslt (o_ma_alu_rslt), .i_wb (o_ma_wb),
        .o_checked (checked), .o_errors (errors)
    );

    //////////////////////////////////////////////////////////////////////
    // stimulus source and reference model
    //////////////////////////////////////////////////////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
    function automatic logic [`WIDTH-1:0] lfsr_bits(input int n);
        logic [`WIDTH-1:0] v;
        logic              fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[`WIDTH-2:0], fb};
        end
        return v;
    endfunction

    // expected payload after the edge that ends the current cycle
    function automatic mawb_t ref_stage_ma(output bit mem_ok);
        mawb_t             nxt;
        logic [`WIDTH-1:0] st;
        logic [5:0]        widx;
        logic [4:0]        vidx;
        bit                vic;
        vic    = (i_ma_alu_rslt[31:28] == `VIC_REGION);
        widx   = i_ma_alu_rslt[7:2];     // bits above 7 ignored, memory wraps
        vidx   = i_ma_alu_rslt[6:2];
        st     = i_op1_mem_s ? i_ma_mux_wb : i_ma_rs2_val;
        mem_ok = vic || written[widx];
        nxt.rdst     = i_ma_rdst;
        nxt.pc       = i_ma_pc;
        nxt.mem_data = vic ? {28'd0, vic_model[vidx]} : mem_model[widx];  // read before write
        nxt.alu_rslt = i_ma_alu_rslt;
        nxt.wb       = i_ma_wb;
        if (i_ma_flush) begin
            nxt    = '0;
            mem_ok = 1'b1;
        end else if (i_ma_stall) begin
            nxt    = prev_exp;       // slot held
            mem_ok = prev_chk;
        end
        // only stall blocks the write, flush does not
        if (i_ma_op == MA_STORE && !i_ma_stall) begin
            if (vic) begin
                vic_model[vidx] = st[3:0];   // narrow bank
            end else begin
                mem_model[widx] = st;
                written[widx]   = 1'b1;
            end
        end
        prev_exp = nxt;
        prev_chk = mem_ok;
        return nxt;
    endfunction

    task automatic drive_op(input int n);
        logic [2:0] slot;    // small pool so loads hit earlier stores
        logic [3:0] top;
        logic [1:0] kind;
        bit         vic;
        slot = 3'(lfsr_bits(3));
        vic  = (lfsr_bits(2) == 0) || (n == 0);   // about one in four
        kind = 2'(lfsr_bits(2));
        top  = vic ? `VIC_REGION : 4'(lfsr_bits(4));
        if (!vic && top == `VIC_REGION) top = 4'h0;
        i_ma_alu_rslt = {top, 20'(lfsr_bits(20)), 3'b000, slot, 2'b00};
        case (kind)
            2'd0:    i_ma_op = MA_NONE;
            2'd1:    i_ma_op = MA_STORE;
            default: i_ma_op = MA_LOAD;
        endcase
        if (n == 0) i_ma_op = MA_LOAD;              // fresh vic register read
        if (i_ma_op == MA_LOAD && !vic && !written[{3'b000, slot}]) i_ma_op = MA_STORE;
        i_ma_rs2_val = lfsr_bits(32);
        i_ma_mux_wb  = lfsr_bits(32);
        i_op1_mem_s  = 1'(lfsr_bits(1));
        i_ma_pc      = lfsr_bits(32);
        i_ma_rdst    = 5'(lfsr_bits(5));
        i_ma_wb      = 3'(lfsr_bits(3));
        i_ma_stall   = (lfsr_bits(3) == 0);         // ~1 in 8
        i_ma_flush   = (lfsr_bits(4) == 0);         // ~1 in 16
        exp_pay      = ref_stage_ma(exp_mem_chk);
        exp_valid    = 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence and run limit
    //////////////////////////////////////////////////////////////////////
    initial begin
        i_rst         = 1'b1;
        i_ma_wb       = '0;
        i_ma_op       = MA_NONE;
        i_ma_alu_rslt = '0;
        i_ma_rs2_val  = '0;
        i_ma_pc       = '0;
        i_ma_rdst     = '0;
        i_ma_mux_wb   = '0;
        i_op1_mem_s   = 1'b0;
        i_ma_flush    = 1'b0;
        i_ma_stall    = 1'b0;
        exp_valid     = 1'b0;
        exp_pay       = '0;
        exp_mem_chk   = 1'b0;
        for (int i = 0; i < `CONFREG_COUNT; i++) begin
            vic_model[i] = 4'h0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst = 1'b0;
        for (int n = 0; n < NUM_OPS; n++) begin
            drive_op(n);
            @(negedge clk);
        end
        exp_valid = 1'b0;
        i_ma_op   = MA_NONE;
        while (checked < NUM_OPS) @(posedge clk);
        $display("checks %0d errors %0d", checked, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d checks and %0d errors",
                     cycles, checked, errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

//--- stage_ma.f
+incdir+common
common/ma_pkg.sv
common/ma_req_if.sv
design/ma_access_ctrl.sv
design/ma_dmem.sv
design/ma_vic_regs.sv
design/ma_wb_reg.sv
design/stage_ma.sv
test/ma_checker.sv
test/tb_stage_ma.sv

//--- run_sim.sh
#!/bin/sh
# build and run the stage_ma testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f stage_ma.f \
    --top-module tb_stage_ma \
    -o sim_stage_ma

out=$(./obj_dir/sim_stage_ma)
echo "$out"

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
